/* rtl/apb_master.sv */
module apb_master (
    input  logic        clk,
    input  logic        reset,
    input  logic        xfer_req,
    input  logic        xfer_write,
    input  logic [31:0] xfer_addr,
    input  logic [31:0] xfer_wdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    output logic        xfer_done,
    output logic [31:0] xfer_rdata,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] paddr,
    output logic [31:0] pwdata
);

    dcache_pkg::apb_phase_e phase;
    logic start;
    logic finish;

    // req is still high in the done cycle, so skip it there
    assign start  = (phase == dcache_pkg::ap_idle) && xfer_req && !xfer_done;
    assign finish = (phase == dcache_pkg::ap_access) && pready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= dcache_pkg::ap_idle;
            psel      <= 1'b0;
            penable   <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= finish;
            case (phase)
                dcache_pkg::ap_idle: begin
                    if (start) begin
                        psel  <= 1'b1;
                        phase <= dcache_pkg::ap_setup;
                    end
                end
                dcache_pkg::ap_setup: begin
                    penable <= 1'b1;
                    phase   <= dcache_pkg::ap_access;
                end
                default: begin
                    if (pready) begin  // wait states hold us here
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        phase   <= dcache_pkg::ap_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pwrite <= xfer_write;
            paddr  <= {xfer_addr[31:2], 2'b00};
            pwdata <= xfer_wdata;
        end
        if (finish) begin
            xfer_rdata <= prdata;
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        psel && penable |-> $stable(paddr) && $stable(pwrite)
    );

endmodule

/* rtl/dcache_data_store.sv */
module dcache_data_store (
    input  logic                             clk,
    input  logic [dcache_pkg::index_w-1:0]    hit_index,
    input  logic [dcache_pkg::word_sel_w-1:0] hit_word,
    input  logic [3:0]                       hit_byte_en,
    input  logic [31:0]                      hit_wdata,
    input  logic [dcache_pkg::index_w-1:0]    victim_index,
    input  logic [dcache_pkg::word_sel_w-1:0] victim_word,
    input  logic                             refill_we,
    input  logic [dcache_pkg::index_w-1:0]    refill_index,
    input  logic [dcache_pkg::word_sel_w-1:0] refill_word,
    input  logic [31:0]                      refill_wdata,
    output logic [31:0]                      hit_rdata,
    output logic [31:0]                      victim_rdata
);

    logic [31:0] mem [dcache_pkg::num_lines][dcache_pkg::words_per_line];

    // both read ports are asynchronous
    assign hit_rdata    = mem[hit_index][hit_word];
    assign victim_rdata = mem[victim_index][victim_word];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (hit_byte_en[b]) begin
                mem[hit_index][hit_word][8*b +: 8] <= hit_wdata[8*b +: 8];
            end
        end
        if (refill_we) begin
            mem[refill_index][refill_word] <= refill_wdata;  // whole word from memory
        end
    end

    // hit writes and refill writes are separated by the lookup FSM
    a_one_writer: assert property (
        @(posedge clk) !((|hit_byte_en) && refill_we)
    );

endmodule

/* rtl/dcache_lookup.sv */
module dcache_lookup (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [31:0]                      addr,
    input  logic                             read_en,
    input  logic                             write_en,
    input  logic [31:0]                      write_data,
    input  dcache_pkg::access_size_e         size,
    input  logic [dcache_pkg::tag_w-1:0]      look_tag,
    input  logic                             look_valid,
    input  logic                             look_dirty,
    input  logic [31:0]                      hit_rdata,
    input  logic                             miss_done,
    output logic [31:0]                      read_data,
    output logic                             hit,
    output logic                             ready,
    output logic [dcache_pkg::index_w-1:0]    look_index,
    output logic                             set_dirty,
    output logic [dcache_pkg::index_w-1:0]    hit_index,
    output logic [dcache_pkg::word_sel_w-1:0] hit_word,
    output logic [3:0]                       hit_byte_en,
    output logic [31:0]                      hit_wdata,
    output logic                             miss_req,
    output logic [dcache_pkg::index_w-1:0]    miss_index,
    output logic [dcache_pkg::tag_w-1:0]      miss_tag,
    output logic [dcache_pkg::tag_w-1:0]      victim_tag,
    output logic                             victim_dirty
);

    dcache_pkg::lookup_state_e state;
    logic [dcache_pkg::tag_w-1:0] tag;
    logic [dcache_pkg::index_w-1:0] index;
    logic [1:0] byte_off;
    logic [3:0] size_mask;
    logic [31:0] shifted;
    logic [31:0] aligned;
    logic tag_match;
    logic serve;

    assign tag      = addr[31 -: dcache_pkg::tag_w];
    assign index    = addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
    assign byte_off = addr[1:0];

    assign look_index = index;
    assign hit_index  = index;
    assign hit_word   = addr[2 +: dcache_pkg::word_sel_w];
    assign tag_match  = look_valid && (look_tag == tag);

    // first pass hit, or the retry once the line has landed
    assign serve = (state == dcache_pkg::lk_idle && (read_en || write_en) && tag_match) ||
                   (state == dcache_pkg::lk_wait_miss && miss_done);

    always_comb begin
        case (size)
            dcache_pkg::size_byte: begin
                size_mask = 4'b0001;
                hit_wdata = {4{write_data[7:0]}};
            end
            dcache_pkg::size_half: begin
                size_mask = 4'b0011;
                hit_wdata = {2{write_data[15:0]}};
            end
            default: begin
                size_mask = 4'b1111;
                hit_wdata = write_data;
            end
        endcase
    end

    assign set_dirty   = serve && write_en;
    assign hit_byte_en = set_dirty ? (size_mask << byte_off) : 4'b0000;

    // shift down and zero-extend
    assign shifted = hit_rdata >> {byte_off, 3'b000};
    assign aligned = shifted & {{8{size_mask[3]}}, {8{size_mask[2]}},
                                {8{size_mask[1]}}, {8{size_mask[0]}}};

    // requester holds addr through the miss, so these stay valid
    assign miss_index   = index;
    assign miss_tag     = tag;
    assign victim_tag   = look_tag;
    assign victim_dirty = look_valid && look_dirty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= dcache_pkg::lk_idle;
            ready    <= 1'b0;
            hit      <= 1'b0;
            miss_req <= 1'b0;
        end else begin
            ready <= 1'b0;
            hit   <= 1'b0;
            case (state)
                dcache_pkg::lk_idle: begin
                    if (serve) begin
                        ready <= 1'b1;
                        hit   <= 1'b1;
                        state <= dcache_pkg::lk_respond;
                    end else if (read_en || write_en) begin
                        miss_req <= 1'b1;
                        state    <= dcache_pkg::lk_wait_miss;
                    end
                end
                dcache_pkg::lk_wait_miss: begin
                    if (miss_done) begin
                        miss_req <= 1'b0;
                        ready    <= 1'b1;  // hit stays low
                        state    <= dcache_pkg::lk_respond;
                    end
                end
                default: state <= dcache_pkg::lk_idle;  // enables ignored here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            read_data <= aligned;
        end
    end

    a_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (read_en || write_en) && state == dcache_pkg::lk_idle |->
            (size == dcache_pkg::size_byte) ||
            (size == dcache_pkg::size_half && !addr[0]) ||
            (size == dcache_pkg::size_word && addr[1:0] == 2'b00)
    );

    a_one_enable: assert property (
        @(posedge clk) disable iff (reset) !(read_en && write_en)
    );

endmodule

/* rtl/dcache_miss_ctrl.sv */
module dcache_miss_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             miss_req,
    input  logic [dcache_pkg::index_w-1:0]    miss_index,
    input  logic [dcache_pkg::tag_w-1:0]      miss_tag,
    input  logic [dcache_pkg::tag_w-1:0]      victim_tag,
    input  logic                             victim_dirty,
    input  logic [31:0]                      victim_rdata,
    input  logic                             xfer_done,
    input  logic [31:0]                      xfer_rdata,
    output logic                             miss_done,
    output logic [dcache_pkg::index_w-1:0]    victim_index,
    output logic [dcache_pkg::word_sel_w-1:0] victim_word,
    output logic                             refill_we,
    output logic [dcache_pkg::index_w-1:0]    refill_index,
    output logic [dcache_pkg::word_sel_w-1:0] refill_word,
    output logic [31:0]                      refill_wdata,
    output logic                             install,
    output logic [dcache_pkg::index_w-1:0]    install_index,
    output logic [dcache_pkg::tag_w-1:0]      install_tag,
    output logic                             xfer_req,
    output logic                             xfer_write,
    output logic [31:0]                      xfer_addr,
    output logic [31:0]                      xfer_wdata
);

    dcache_pkg::miss_state_e state;
    logic [dcache_pkg::word_sel_w-1:0] word_cnt;
    logic last_word;

    assign last_word = (word_cnt == dcache_pkg::words_per_line - 1);

    // victim words leave in order
    assign victim_index = miss_index;
    assign victim_word  = word_cnt;
    assign xfer_write   = (state == dcache_pkg::ms_writeback);
    assign xfer_wdata   = victim_rdata;
    assign xfer_addr    = xfer_write ? {victim_tag, miss_index, word_cnt, 2'b00}
                                     : {miss_tag, miss_index, word_cnt, 2'b00};

    // refill words go straight into the array as they arrive
    assign refill_we    = (state == dcache_pkg::ms_refill) && xfer_done;
    assign refill_index = miss_index;
    assign refill_word  = word_cnt;
    assign refill_wdata = xfer_rdata;

    assign install       = (state == dcache_pkg::ms_done);
    assign install_index = miss_index;
    assign install_tag   = miss_tag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= dcache_pkg::ms_idle;
            word_cnt  <= '0;
            xfer_req  <= 1'b0;
            miss_done <= 1'b0;
        end else begin
            miss_done <= 1'b0;
            case (state)
                dcache_pkg::ms_idle: begin
                    // miss_req is still up during the done pulse
                    if (miss_req && !miss_done) begin
                        word_cnt <= '0;
                        xfer_req <= 1'b1;
                        state    <= victim_dirty ? dcache_pkg::ms_writeback
                                                 : dcache_pkg::ms_refill;
                    end
                end
                dcache_pkg::ms_writeback: begin
                    if (xfer_done) begin
                        word_cnt <= word_cnt + 1'b1;  // wraps to 0 for refill
                        if (last_word) begin
                            state <= dcache_pkg::ms_refill;
                        end
                    end
                end
                dcache_pkg::ms_refill: begin
                    if (xfer_done) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            xfer_req <= 1'b0;
                            state    <= dcache_pkg::ms_done;
                        end
                    end
                end
                default: begin
                    miss_done <= 1'b1;  // tag written at this edge
                    state     <= dcache_pkg::ms_idle;
                end
            endcase
        end
    end

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry, 1 KiB direct mapped
    localparam int line_bytes = 16;
    localparam int num_lines = 64;
    localparam int words_per_line = line_bytes / 4;

    // address split: tag | index | word | byte
    localparam int offset_w = $clog2(line_bytes);
    localparam int word_sel_w = $clog2(words_per_line);
    localparam int index_w = $clog2(num_lines);
    localparam int tag_w = 32 - index_w - offset_w;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        lk_idle,       // waiting for an enable
        lk_respond,    // ready pulse
        lk_wait_miss   // parked until the line is in
    } lookup_state_e;

    typedef enum logic [1:0] {
        ms_idle,
        ms_writeback,
        ms_refill,
        ms_done
    } miss_state_e;

    typedef enum logic [1:0] {
        ap_idle,
        ap_setup,
        ap_access
    } apb_phase_e;

endpackage

/* rtl/dcache_tag_store.sv */
module dcache_tag_store (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [dcache_pkg::index_w-1:0] look_index,
    input  logic                          set_dirty,
    input  logic                          install,
    input  logic [dcache_pkg::index_w-1:0] install_index,
    input  logic [dcache_pkg::tag_w-1:0]   install_tag,
    output logic [dcache_pkg::tag_w-1:0]   look_tag,
    output logic                          look_valid,
    output logic                          look_dirty
);

    logic [dcache_pkg::tag_w-1:0] tag_mem [dcache_pkg::num_lines];
    logic [dcache_pkg::num_lines-1:0] valid_bits;
    logic [dcache_pkg::num_lines-1:0] dirty_bits;

    // combinational lookup port
    assign look_tag   = tag_mem[look_index];
    assign look_valid = valid_bits[look_index];
    assign look_dirty = dirty_bits[look_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (install) begin
            valid_bits[install_index] <= 1'b1;
            dirty_bits[install_index] <= 1'b0;  // fresh line is clean
        end else if (set_dirty) begin
            dirty_bits[look_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_mem[install_index] <= install_tag;
        end
    end

    // lookup only writes while the miss controller is idle
    a_no_dirty_on_install: assert property (
        @(posedge clk) disable iff (reset) !(set_dirty && install)
    );

endmodule

/* rtl/dcache_top.sv */
module dcache_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              addr,
    input  logic                     read_en,
    input  logic                     write_en,
    input  logic [31:0]              write_data,
    input  dcache_pkg::access_size_e size,
    input  logic [31:0]              prdata,
    input  logic                     pready,
    output logic [31:0]              read_data,
    output logic                     hit,
    output logic                     ready,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [31:0]              paddr,
    output logic [31:0]              pwdata
);

    logic [dcache_pkg::index_w-1:0] look_index, hit_index, miss_index;
    logic [dcache_pkg::index_w-1:0] victim_index, refill_index, install_index;
    logic [dcache_pkg::tag_w-1:0] look_tag, miss_tag, victim_tag, install_tag;
    logic [dcache_pkg::word_sel_w-1:0] hit_word, victim_word, refill_word;
    logic look_valid, look_dirty, set_dirty, install;
    logic [3:0] hit_byte_en;
    logic [31:0] hit_wdata, hit_rdata, victim_rdata, refill_wdata;
    logic miss_req, miss_done, victim_dirty, refill_we;
    logic xfer_req, xfer_write, xfer_done;
    logic [31:0] xfer_addr, xfer_wdata, xfer_rdata;

    dcache_lookup u_lookup (
        .clk, .reset, .addr, .read_en, .write_en, .write_data, .size,
        .look_tag, .look_valid, .look_dirty, .hit_rdata, .miss_done,
        .read_data, .hit, .ready, .look_index, .set_dirty,
        .hit_index, .hit_word, .hit_byte_en, .hit_wdata,
        .miss_req, .miss_index, .miss_tag, .victim_tag, .victim_dirty
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk, .reset, .miss_req, .miss_index, .miss_tag, .victim_tag, .victim_dirty,
        .victim_rdata, .xfer_done, .xfer_rdata, .miss_done, .victim_index, .victim_word,
        .refill_we, .refill_index, .refill_word, .refill_wdata,
        .install, .install_index, .install_tag,
        .xfer_req, .xfer_write, .xfer_addr, .xfer_wdata
    );

    apb_master u_apb (
        .clk, .reset, .xfer_req, .xfer_write, .xfer_addr, .xfer_wdata,
        .prdata, .pready, .xfer_done, .xfer_rdata,
        .psel, .penable, .pwrite, .paddr, .pwdata
    );

    dcache_tag_store u_tags (
        .clk, .reset, .look_index, .set_dirty, .install, .install_index, .install_tag,
        .look_tag, .look_valid, .look_dirty
    );

    dcache_data_store u_data (
        .clk, .hit_index, .hit_word, .hit_byte_en, .hit_wdata,
        .victim_index, .victim_word, .refill_we, .refill_index, .refill_word,
        .refill_wdata, .hit_rdata, .victim_rdata
    );

endmodule

/* src.f */
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_lookup.sv
rtl/dcache_miss_ctrl.sv
rtl/apb_master.sv
rtl/dcache_top.sv
testbench/apb_mem_model.sv
testbench/tb_dcache.sv

/* testbench/apb_mem_model.sv */
module apb_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    localparam int depth = 4096;  // words, 16 KiB
    localparam int max_waits = 3;

    logic [31:0] words [depth];  // filled by the testbench before reset ends
    int waits_left;
    int range_errors;

    initial begin
        prdata = '0;
        pready = 1'b0;
        waits_left = 0;
        range_errors = 0;
    end

    // responses change on the falling edge, the master samples on the rising one
    always @(negedge clk) begin
        if (reset) begin
            pready = 1'b0;
            waits_left = 0;
        end else if (psel && !penable) begin
            waits_left = $urandom_range(max_waits, 0);  // stretch picked in setup
            pready = 1'b0;
        end else if (psel && penable && !pready) begin
            if (waits_left > 0) begin
                waits_left--;
            end else begin
                if (paddr >= depth * 4) begin
                    range_errors++;  // outside the backing store
                end else if (pwrite) begin
                    words[paddr[13:2]] = pwdata;
                end else begin
                    prdata = words[paddr[13:2]];
                end
                pready = 1'b1;
            end
        end else begin
            pready = 1'b0;
        end
    end

endmodule

/* testbench/tb_dcache.sv */
module tb_dcache;

    localparam int num_directed = 21;
    localparam int num_random = 400;
    localparam int timeout_cycles = (num_directed + num_random) * 60;
    localparam int mem_bytes = 16384;

    logic clk;
    logic reset;
    logic [31:0] addr;
    logic read_en;
    logic write_en;
    logic [31:0] write_data;
    dcache_pkg::access_size_e size;
    logic [31:0] read_data;
    logic hit;
    logic ready;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;

    logic [7:0] ref_bytes [mem_bytes];  // what a program sees
    logic [dcache_pkg::tag_w-1:0] shadow_tag [dcache_pkg::num_lines];
    logic shadow_valid [dcache_pkg::num_lines];
    int checks;
    int errors;
    int cycle_count;

    dcache_top dut (
        .clk, .reset, .addr, .read_en, .write_en, .write_data, .size,
        .prdata, .pready, .read_data, .hit, .ready,
        .psel, .penable, .pwrite, .paddr, .pwdata
    );

    apb_mem_model mem (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // initial memory contents, address mixed with a constant
    function automatic logic [31:0] fill_word(input int unsigned a);
        return (a * 32'h9e37_79b1) ^ 32'ha5a5_0f0f;
    endfunction

    function automatic logic [31:0] ref_word(input int unsigned a);
        return {ref_bytes[a + 3], ref_bytes[a + 2], ref_bytes[a + 1], ref_bytes[a]};
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAIL t=%0t: %s", $time, msg);
    endtask

    task automatic close_test(input string name, input int errors_before);
        $display("test %s: %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    // one CPU access, called right after a falling edge
    task automatic access(input logic [31:0] a, input logic wr, input int sz,
                          input logic [31:0] wd);
        logic [dcache_pkg::index_w-1:0] idx;
        logic [dcache_pkg::tag_w-1:0] t;
        logic [dcache_pkg::tag_w-1:0] old_tag;
        logic [31:0] exp_data;
        logic [31:0] vaddr;
        logic exp_hit;
        logic evict;
        int waited;
        idx = a[dcache_pkg::offset_w +: dcache_pkg::index_w];
        t = a[31 -: dcache_pkg::tag_w];
        exp_hit = shadow_valid[idx] && (shadow_tag[idx] == t);
        evict = shadow_valid[idx] && !exp_hit;
        old_tag = shadow_tag[idx];
        exp_data = '0;
        for (int i = 0; i < (1 << sz); i++) begin
            exp_data[8*i +: 8] = ref_bytes[a + i];
            if (wr) begin
                ref_bytes[a + i] = wd[8*i +: 8];  // low bytes land on the addressed lanes
            end
        end
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx] = t;
        addr = a;
        read_en = !wr;
        write_en = wr;
        write_data = wd;
        size = dcache_pkg::access_size_e'(sz);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ready);
        read_en = 1'b0;
        write_en = 1'b0;
        checks++;
        if (hit !== exp_hit) begin
            report_mismatch($sformatf("addr %h hit %b, expected %b", a, hit, exp_hit));
        end
        if (exp_hit) begin
            checks++;
            if (waited != 1) begin
                report_mismatch($sformatf("addr %h hit took %0d cycles", a, waited));
            end
        end
        if (!wr) begin
            checks++;
            if (read_data !== exp_data) begin
                report_mismatch($sformatf("addr %h size %0d read %h, expected %h",
                                          a, sz, read_data, exp_data));
            end
        end
        if (evict) begin
            for (int w = 0; w < dcache_pkg::words_per_line; w++) begin
                vaddr = {old_tag, idx, 4'b0000} + 4 * w;
                checks++;
                if (mem.words[vaddr[13:2]] !== ref_word(vaddr)) begin
                    report_mismatch($sformatf("evicted word %h is %h in memory, expected %h",
                                              vaddr, mem.words[vaddr[13:2]], ref_word(vaddr)));
                end
            end
        end
        @(negedge clk);  // let the lookup stage leave lk_respond
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] a;
        int sz;
        int mark;
        void'($urandom(1));
        clk = 1'b0;
        reset = 1'b1;
        addr = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        write_data = '0;
        size = dcache_pkg::size_word;
        checks = 0;
        errors = 0;
        for (int i = 0; i < mem_bytes / 4; i++) begin
            w = fill_word(4 * i);
            mem.words[i] = w;
            for (int b = 0; b < 4; b++) begin
                ref_bytes[4*i + b] = w[8*b +: 8];
            end
        end
        for (int i = 0; i < dcache_pkg::num_lines; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        mark = errors;
        checks++;
        if (ready !== 1'b0 || hit !== 1'b0 || psel !== 1'b0 || penable !== 1'b0) begin
            report_mismatch("ready, hit, psel or penable not low after reset");
        end
        access(32'h100, 1'b0, 2, '0);  // cold miss
        close_test("reset and first miss", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            access(32'h100 + i, 1'b0, 0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            access(32'h108 + 2 * i, 1'b0, 1, '0);
        end
        close_test("read hits", mark);

        mark = errors;
        access(32'h101, 1'b1, 0, 32'h0000_00c3);
        access(32'h106, 1'b1, 1, 32'h0000_b00f);
        access(32'h108, 1'b1, 2, 32'hdead_beef);
        for (int i = 0; i < 3; i++) begin
            access(32'h100 + 4 * i, 1'b0, 2, '0);
        end
        close_test("write hits", mark);

        mark = errors;
        access(32'h500, 1'b0, 2, '0);  // same index, other tag, dirty victim
        access(32'h100, 1'b0, 1, '0);  // old line comes back with a miss
        close_test("dirty eviction", mark);

        mark = errors;
        for (int n = 0; n < num_random; n++) begin
            sz = $urandom % 3;
            a = $urandom % 4096;  // four tags, plenty of conflicts
            if (sz >= 1) begin
                a[0] = 1'b0;
            end
            if (sz == 2) begin
                a[1] = 1'b0;
            end
            access(a, 1'($urandom % 2), sz, $urandom);
        end
        checks++;
        if (mem.range_errors != 0) begin
            errors++;
            $display("memory model saw %0d transfers outside its array", mem.range_errors);
        end
        close_test("random accesses", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
